// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);
    localparam time HALF_PERIOD = 5ns;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset released just after the 8th rising edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end
endmodule

// ==== bench/mem_checker.sv ====
`timescale 1ns/1ps

module mem_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  logic        req_ready,
    input  logic [31:0] addr,
    input  int          pat_idx,
    input  logic [31:0] exp_rdata,
    input  logic [31:0] exp_side,
    input  logic [7:0]  exp_flags,
    input  logic        rsp_valid,
    input  logic        rsp_ready,
    input  logic [31:0] rsp_rdata,
    input  logic        rsp_is_load,
    input  logic        rsp_wrote_dmem,
    input  logic        rsp_wrote_io,
    input  logic        imem_we,
    input  logic [29:0] imem_addr,
    input  logic [31:0] imem_wdata,
    input  logic [3:0]  imem_mask,
    input  logic [31:0] io_out,
    output int          rsp_count,
    output int          check_count,
    output int          error_count
);
    // Entries hold pattern index, rdata, side value and flags
    logic [103:0] exp_q [$];
    logic [103:0] head;
    int           n_rsp = 0;
    int           n_chk = 0;
    int           n_err = 0;
    logic         imem_pending = 1'b0;
    int           imem_idx;
    logic [29:0]  imem_exp_addr;
    logic [31:0]  imem_exp_data;
    logic [3:0]   imem_exp_mask;

    assign rsp_count   = n_rsp;
    assign check_count = n_chk;
    assign error_count = n_err;

    task automatic check_value(input int idx, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        n_chk++;
        if (expected !== actual) begin
            n_err++;
            $display("error pattern_%0d %s: expected %08h, actual %08h",
                     idx, what, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            // IMEM pulse belongs to the request accepted one edge earlier
            if (imem_pending) begin
                imem_pending = 1'b0;
                if (!imem_we) begin
                    n_err++;
                    $display("pattern_%0d: instruction memory write pulse is missing", imem_idx);
                end else begin
                    check_value(imem_idx, "imem_addr", {2'b0, imem_exp_addr}, {2'b0, imem_addr});
                    check_value(imem_idx, "imem_wdata", imem_exp_data, imem_wdata);
                    check_value(imem_idx, "imem_mask", {28'h0, imem_exp_mask}, {28'h0, imem_mask});
                end
            end else if (imem_we) begin
                n_err++;
                $display("Unexpected instruction memory write to word %08h", imem_addr);
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    n_err++;
                    $display("A response arrived with no request outstanding");
                end else begin
                    head = exp_q.pop_front();
                    n_rsp++;
                    check_value(head[103:72], "rdata", head[71:40], rsp_rdata);
                    check_value(head[103:72], "is_load", 32'(head[0]), 32'(rsp_is_load));
                    check_value(head[103:72], "wrote_dmem", 32'(head[1]), 32'(rsp_wrote_dmem));
                    check_value(head[103:72], "wrote_io", 32'(head[2]), 32'(rsp_wrote_io));
                    if (head[2]) begin
                        check_value(head[103:72], "io_out", head[39:8], io_out);
                    end
                end
            end
            if (req_valid && req_ready) begin
                exp_q.push_back({pat_idx, exp_rdata, exp_side, exp_flags});
                if (exp_flags[3]) begin
                    imem_pending  = 1'b1;
                    imem_idx      = pat_idx;
                    imem_exp_addr = addr[31:2];
                    imem_exp_data = exp_side;
                    imem_exp_mask = exp_flags[7:4];
                end
            end
        end
    end
endmodule

// ==== bench/mem_patterns.txt ====
// inst pc addr wdata exp_rdata exp_side(imem_wdata or io_out) flags
// flags: [7:4] imem_mask, [3] imem_we, [2] wrote_io, [1] wrote_dmem, [0] is_load
00002023 00000100 10000040 11223344 00000000 00000000 00000002
00002003 00000100 10000040 00000000 11223344 00000000 00000001
00000023 00000100 10000041 000000aa 00000000 00000000 00000002
00001023 00000100 10000042 0000beef 00000000 00000000 00000002
00002003 00000100 10000040 00000000 beefaa44 00000000 00000001
00000003 00000100 10000041 00000000 ffffffaa 00000000 00000001
00004003 00000100 10000041 00000000 000000aa 00000000 00000001
00001003 00000100 10000042 00000000 ffffbeef 00000000 00000001
00005003 00000100 10000042 00000000 0000beef 00000000 00000001
00000003 00000100 10000040 00000000 00000044 00000000 00000001
00001023 40000000 20000006 00001234 00000000 12341234 000000c8
00000023 00000100 20000004 00000055 00000000 00000000 00000000
00002023 00000100 80000008 cafe0001 00000000 cafe0001 00000004
00002003 00000100 80000008 00000000 cafe0001 00000000 00000001
00002003 00000100 80000010 00000000 0000000e 00000000 00000001
00002023 00000100 80000018 00000000 00000000 cafe0001 00000004
00000013 00000100 10000040 00000000 00000000 00000000 00000000
00002003 00000100 80000010 00000000 00000001 00000000 00000001
00000063 00000100 00000000 00000000 00000000 00000000 00000000
0000006f 00000100 00000000 00000000 00000000 00000000 00000000
00002003 00000100 00000100 00000000 00000000 00000000 00000001
00000003 40000000 20000000 00000000 00000000 00000000 00000001
00002003 00000100 10000040 00000000 beefaa44 00000000 00000001

// ==== bench/mem_stage_properties.sv ====
`timescale 1ns/1ps

module mem_stage_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        rsp_valid,
    input logic        rsp_ready,
    input logic [31:0] rsp_rdata,
    input logic        rsp_is_load,
    input logic        rsp_wrote_dmem,
    input logic        rsp_wrote_io,
    input logic        imem_we
);
    int failures = 0;

    // A stalled response keeps every field
    a_rsp_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_is_load)
            && $stable(rsp_wrote_dmem) && $stable(rsp_wrote_io)
    ) else begin
        failures++;
        $error("held response changed before rsp_ready");
    end

    a_imem_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) imem_we |=> !imem_we
    ) else begin
        failures++;
        $error("imem_we stayed high for more than one cycle");
    end

    a_reset_idle: assert property (
        @(posedge clk) !rst_n |-> !rsp_valid && !imem_we
    ) else begin
        failures++;
        $error("rsp_valid or imem_we high during reset");
    end
endmodule

// ==== bench/tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage;
    localparam int N_PATS          = 23;
    localparam int WORDS           = 7;
    localparam int DMEM_DEPTH      = 256;
    localparam int WATCHDOG_CYCLES = N_PATS * 20 + 100;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic        req_ready;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] rsp_rdata;
    logic        rsp_is_load;
    logic        rsp_wrote_dmem;
    logic        rsp_wrote_io;
    logic        imem_we;
    logic [29:0] imem_addr;
    logic [31:0] imem_wdata;
    logic [3:0]  imem_mask;
    logic [31:0] io_out;
    logic [31:0] pats [N_PATS*WORDS];
    int          pat_idx;
    logic [31:0] exp_rdata;
    logic [31:0] exp_side;
    logic [7:0]  exp_flags;
    int          rsp_count;
    int          check_count;
    int          error_count;
    logic        taken;

    clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    mem_stage #(.DMEM_DEPTH(DMEM_DEPTH)) i_mem_stage (.*);

    mem_checker i_checker (.*);

    bind mem_stage mem_stage_properties i_props (.*);

    task automatic load_request(input int i);
        inst      = pats[i*WORDS];
        pc        = pats[i*WORDS + 1];
        addr      = pats[i*WORDS + 2];
        wdata     = pats[i*WORDS + 3];
        exp_rdata = pats[i*WORDS + 4];
        exp_side  = pats[i*WORDS + 5];
        exp_flags = pats[i*WORDS + 6][7:0];
        pat_idx   = i;
    endtask

    // req_ready is settled by the falling edge
    task automatic wait_accept();
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drive_backpressure();
        forever begin
            @(posedge clk);
            #1;
            rsp_ready = ($urandom % 4) != 0;
        end
    endtask

    initial begin
        void'($urandom(32'h72f0));
        req_valid = 1'b0;
        inst      = 32'h0;
        pc        = 32'h0;
        addr      = 32'h0;
        wdata     = 32'h0;
        rsp_ready = 1'b0;
        pat_idx   = 0;
        exp_rdata = 32'h0;
        exp_side  = 32'h0;
        exp_flags = 8'h0;
        $readmemh("bench/mem_patterns.txt", pats);
        fork
            drive_backpressure();
        join_none
        @(posedge rst_n);
        @(posedge clk);
        #1;
        for (int i = 0; i < N_PATS; i++) begin
            load_request(i);
            req_valid = 1'b1;
            wait_accept();
        end
        req_valid = 1'b0;
        wait (rsp_count == N_PATS);
        @(posedge clk);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, i_mem_stage.i_props.failures);
        if (error_count == 0 && i_mem_stage.i_props.failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: responses did not all arrive within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end
endmodule

// ==== build.f ====
src/mem_pkg.sv
src/mem_wr_if.sv
src/load_align.sv
src/data_mem.sv
src/io_regs.sv
src/mem_control.sv
src/mem_stage.sv
bench/clk_gen.sv
bench/mem_stage_properties.sv
bench/mem_checker.sv
bench/tb_mem_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mem_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_stage -f build.f \
    > sim.log 2>&1 && ./obj_dir/Vtb_mem_stage >> sim.log 2>&1
grep -q "^TB PASSED$" sim.log && echo "Simulation passed" || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== src/data_mem.sv ====
`timescale 1ns/1ps

module data_mem #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic        clk,
    mem_wr_if.mem       bus,
    output logic [31:0] rdata
);
    localparam int IDX_W = $clog2(DMEM_DEPTH);

    logic [31:0]      mem [DMEM_DEPTH];
    logic [29:0]      word_mod;
    logic [IDX_W-1:0] idx;

    // Address wraps onto the array
    assign word_mod = bus.word_addr % 30'(DMEM_DEPTH);
    assign idx      = word_mod[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (bus.en) begin
            if (bus.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.mask[b]) begin
                        mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                    end
                end
            end else begin
                // Read word holds while en is low
                rdata <= mem[idx];
            end
        end
    end

endmodule

// ==== src/io_regs.sv ====
`timescale 1ns/1ps

module io_regs (
    input  logic        clk,
    input  logic        rst_n,
    mem_wr_if.mem       bus,
    input  logic        req_accepted,
    output logic [31:0] rdata,
    output logic [31:0] io_out
);
    import mem_pkg::*;

    logic [31:0] count;
    logic        out_wr;
    logic        count_clr;

    assign out_wr    = bus.en && bus.we && (bus.word_addr == IO_OUT_ADDR[31:2]);
    assign count_clr = bus.en && bus.we && (bus.word_addr == IO_COUNT_CLR_ADDR[31:2]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            io_out <= 32'h0;
            count  <= 32'h0;
        end else begin
            if (out_wr) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.mask[b]) begin
                        io_out[8*b +: 8] <= bus.wdata[8*b +: 8];
                    end
                end
            end
            // Clear wins over the increment
            if (count_clr) begin
                count <= 32'h0;
            end else if (req_accepted) begin
                count <= count + 32'd1;
            end
        end
    end

    // Count read here is the value before this request
    always_ff @(posedge clk) begin
        if (bus.en && !bus.we) begin
            case (bus.word_addr)
                IO_OUT_ADDR[31:2]:   rdata <= io_out;
                IO_COUNT_ADDR[31:2]: rdata <= count;
                default:             rdata <= 32'h0;
            endcase
        end
    end

endmodule

// ==== src/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  logic [31:0] word,
    input  logic [2:0]  funct3,
    input  logic [1:0]  offset,
    input  logic        is_load,
    output logic [31:0] rdata
);
    import mem_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_sel = word[8*offset +: 8];
    // Halfword lane picked by bit 1 only
    assign half_sel = offset[1] ? word[31:16] : word[15:0];

    always_comb begin
        if (!is_load) begin
            rdata = 32'h0;
        end else begin
            case (funct3)
                FNC_LB:  rdata = {{24{byte_sel[7]}}, byte_sel};
                FNC_LBU: rdata = {24'h0, byte_sel};
                FNC_LH:  rdata = {{16{half_sel[15]}}, half_sel};
                FNC_LHU: rdata = {16'h0, half_sel};
                FNC_LW:  rdata = word;
                default: rdata = 32'h0;
            endcase
        end
    end

endmodule

// ==== src/mem_control.sv ====
`timescale 1ns/1ps

module mem_control (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  logic [31:0]          inst,
    input  logic [31:0]          pc,
    input  logic [31:0]          addr,
    input  logic [31:0]          wdata,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output mem_pkg::mem_target_e rsp_target,
    output logic                 rsp_is_load,
    output logic [2:0]           rsp_funct3,
    output logic [1:0]           rsp_offset,
    mem_wr_if.ctrl               dmem,
    mem_wr_if.ctrl               io,
    output logic                 imem_we,
    output logic [29:0]          imem_addr,
    output logic [31:0]          imem_wdata,
    output logic [3:0]           imem_mask
);
    import mem_pkg::*;

    logic [4:0]  opcode;
    logic [2:0]  funct3;
    logic        is_load;
    logic        is_store;
    logic        accept;
    mem_target_e target;
    logic [31:0] st_data;
    logic [3:0]  st_mask;

    assign opcode   = inst[6:2];
    assign funct3   = inst[14:12];
    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);

    // Non-memory instructions still get a response
    assign target = (is_load || is_store) ? region_of(addr, pc, is_store) : NONE;

    assign req_ready = !rsp_valid || rsp_ready;
    assign accept    = req_valid && req_ready;

    // Place store data into its byte lanes
    always_comb begin
        case (funct3)
            FNC_SB: begin
                st_data = {4{wdata[7:0]}};
                st_mask = 4'b0001 << addr[1:0];
            end
            FNC_SH: begin
                st_data = {2{wdata[15:0]}};
                st_mask = addr[1] ? 4'b1100 : 4'b0011;
            end
            FNC_SW: begin
                st_data = wdata;
                st_mask = 4'b1111;
            end
            default: begin
                st_data = wdata;
                st_mask = 4'b0000;
            end
        endcase
    end

    assign dmem.en        = accept && (target == DMEM);
    assign dmem.we        = is_store;
    assign dmem.word_addr = addr[31:2];
    assign dmem.wdata     = st_data;
    assign dmem.mask      = st_mask;

    assign io.en        = accept && (target == IO);
    assign io.we        = is_store;
    assign io.word_addr = addr[31:2];
    assign io.wdata     = st_data;
    assign io.mask      = st_mask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid   <= 1'b0;
            rsp_target  <= NONE;
            rsp_is_load <= 1'b0;
            imem_we     <= 1'b0;
        end else begin
            if (accept) begin
                rsp_valid   <= 1'b1;
                rsp_target  <= target;
                rsp_is_load <= is_load;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
            // One-cycle pulse after acceptance
            imem_we <= accept && (target == IMEM);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_funct3 <= funct3;
            rsp_offset <= addr[1:0];
            imem_addr  <= addr[31:2];
            imem_wdata <= st_data;
            imem_mask  <= st_mask;
        end
    end

endmodule

// ==== src/mem_pkg.sv ====
package mem_pkg;

    // Opcode in instruction bits 6:2
    localparam logic [4:0] OPC_LOAD  = 5'b00000;
    localparam logic [4:0] OPC_STORE = 5'b01000;

    // Load funct3
    localparam logic [2:0] FNC_LB  = 3'b000;
    localparam logic [2:0] FNC_LH  = 3'b001;
    localparam logic [2:0] FNC_LW  = 3'b010;
    localparam logic [2:0] FNC_LBU = 3'b100;
    localparam logic [2:0] FNC_LHU = 3'b101;

    // Store funct3
    localparam logic [2:0] FNC_SB = 3'b000;
    localparam logic [2:0] FNC_SH = 3'b001;
    localparam logic [2:0] FNC_SW = 3'b010;

    // Memory-mapped I/O
    localparam logic [31:0] IO_OUT_ADDR       = 32'h8000_0008;
    localparam logic [31:0] IO_COUNT_ADDR     = 32'h8000_0010;
    localparam logic [31:0] IO_COUNT_CLR_ADDR = 32'h8000_0018;

    typedef enum logic [1:0] {
        NONE = 2'd0,
        DMEM = 2'd1,
        IMEM = 2'd2,
        IO   = 2'd3
    } mem_target_e;

    // IMEM is only reachable by stores issued from the BIOS region
    function automatic mem_target_e region_of(
        input logic [31:0] addr,
        input logic [31:0] pc,
        input logic        is_store
    );
        if (addr[31]) begin
            return IO;
        end else if (addr[28]) begin
            return DMEM;
        end else if (is_store && addr[29] && pc[30]) begin
            return IMEM;
        end
        return NONE;
    endfunction

endpackage

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    output logic        req_ready,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output logic [31:0] rsp_rdata,
    output logic        rsp_is_load,
    output logic        rsp_wrote_dmem,
    output logic        rsp_wrote_io,
    output logic        imem_we,
    output logic [29:0] imem_addr,
    output logic [31:0] imem_wdata,
    output logic [3:0]  imem_mask,
    output logic [31:0] io_out
);
    import mem_pkg::*;

    mem_target_e rsp_target;
    logic [2:0]  rsp_funct3;
    logic [1:0]  rsp_offset;
    logic [31:0] dmem_rdata;
    logic [31:0] io_rdata;
    logic [31:0] read_word;

    mem_wr_if dmem_bus ();
    mem_wr_if io_bus ();

    mem_control i_mem_control (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .inst        (inst),
        .pc          (pc),
        .addr        (addr),
        .wdata       (wdata),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp_target  (rsp_target),
        .rsp_is_load (rsp_is_load),
        .rsp_funct3  (rsp_funct3),
        .rsp_offset  (rsp_offset),
        .dmem        (dmem_bus.ctrl),
        .io          (io_bus.ctrl),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .imem_mask   (imem_mask)
    );

    data_mem #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) i_data_mem (
        .clk   (clk),
        .bus   (dmem_bus.mem),
        .rdata (dmem_rdata)
    );

    io_regs i_io_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (io_bus.mem),
        .req_accepted (req_valid && req_ready),
        .rdata        (io_rdata),
        .io_out       (io_out)
    );

    // Pick the read word of the target that was accessed
    always_comb begin
        case (rsp_target)
            DMEM:    read_word = dmem_rdata;
            IO:      read_word = io_rdata;
            default: read_word = 32'h0;
        endcase
    end

    load_align i_load_align (
        .word    (read_word),
        .funct3  (rsp_funct3),
        .offset  (rsp_offset),
        .is_load (rsp_is_load),
        .rdata   (rsp_rdata)
    );

    // Non-memory ops map to NONE, so target plus !load means a store
    assign rsp_wrote_dmem = !rsp_is_load && (rsp_target == DMEM);
    assign rsp_wrote_io   = !rsp_is_load && (rsp_target == IO);

endmodule

// ==== src/mem_wr_if.sv ====
`timescale 1ns/1ps

interface mem_wr_if;
    logic        en;
    logic        we;
    logic [29:0] word_addr;
    logic [31:0] wdata;
    logic [3:0]  mask;

    modport ctrl (
        output en,
        output we,
        output word_addr,
        output wdata,
        output mask
    );

    modport mem (
        input en,
        input we,
        input word_addr,
        input wdata,
        input mask
    );
endinterface
